// ==== include/mem_settings.svh ====
/* Shared packet buffer sizing
   Buffer depth, host bus width and checksum width */

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Buffer size in bytes
`define MEM_BYTES 4096

// Host bus data width
`define WB_DW 32

// Word and byte address widths for a 4 KiB buffer
`define WORD_AW 10
`define BYTE_AW 12

// Modular checksum width
`define SUM_W 16

`endif

// ==== src/mem_pkg.sv ====
/* Types shared by the packet buffer blocks
   Scan engine command and status, RAM port requests */

`include "mem_settings.svh"

package mem_pkg;

  // Scan engine operation
  typedef enum logic {
    OP_FILL = 1'b0,
    OP_CSUM = 1'b1
  } scan_op_e;

  // Command from the register block, go is a single-cycle pulse
  typedef struct packed {
    logic                go;
    scan_op_e            op;
    logic [`BYTE_AW-1:0] start;
    logic [`BYTE_AW:0]   len;
    logic [7:0]          pattern;
  } scan_cmd_t;

  // Done stays set until the next go
  typedef struct packed {
    logic              busy;
    logic              done;
    logic [`SUM_W-1:0] sum;
  } scan_sts_t;

  // Word-wide port A request
  typedef struct packed {
    logic                we;
    logic [`WORD_AW-1:0] addr;
    logic [`WB_DW-1:0]   wdata;
  } ram_a_req_t;

  // Byte-wide port B request
  typedef struct packed {
    logic                we;
    logic [`BYTE_AW-1:0] addr;
    logic [7:0]          wdata;
  } ram_b_req_t;

endpackage

// ==== src/dual_port_bram.sv ====
/* Mixed-width dual-port RAM
   One bit array seen as words on port A and as bytes on port B */

`timescale 1ns/1ps
`include "mem_settings.svh"

module dual_port_bram #(
  parameter int ADataWidth = `WB_DW,
  parameter int BDataWidth = 8,
  parameter int BitDepth   = `MEM_BYTES * 8
) (
  input  logic                  clk_i,
  // Port A, word side
  input  mem_pkg::ram_a_req_t   a_req_i,
  output logic [ADataWidth-1:0] a_data_o,
  // Port B, byte side
  input  mem_pkg::ram_b_req_t   b_req_i,
  output logic [BDataWidth-1:0] b_data_o
);

  // Whole storage as a flat vector, little-endian within a word
  logic [BitDepth-1:0] mem_q;

  // Both ports share one clock, so a single process owns the array
  always_ff @(posedge clk_i)
  begin
    // Port A
    a_data_o <= mem_q[a_req_i.addr*ADataWidth +: ADataWidth];
    if (a_req_i.we)
    begin
      a_data_o <= a_req_i.wdata;
      mem_q[a_req_i.addr*ADataWidth +: ADataWidth] <= a_req_i.wdata;
    end

    // Port B
    b_data_o <= mem_q[b_req_i.addr*BDataWidth +: BDataWidth];
    if (b_req_i.we)
    begin
      b_data_o <= b_req_i.wdata;
      mem_q[b_req_i.addr*BDataWidth +: BDataWidth] <= b_req_i.wdata;
    end
  end

endmodule

// ==== src/wb_mem_slave.sv ====
/* Wishbone classic slave for the packet buffer
   Word access to RAM port A plus the scan engine register file */

`timescale 1ns/1ps
`include "mem_settings.svh"

module wb_mem_slave (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [`BYTE_AW:0]   wb_adr_i,
  input  logic [`WB_DW-1:0]   wb_dat_i,
  output logic [`WB_DW-1:0]   wb_dat_o,
  output logic                wb_ack_o,
  output mem_pkg::ram_a_req_t ram_a_o,
  input  logic [`WB_DW-1:0]   ram_a_data_i,
  output mem_pkg::scan_cmd_t  cmd_o,
  input  mem_pkg::scan_sts_t  sts_i
);
  import mem_pkg::*;

  // Register index, address bits 4:2
  localparam logic [2:0] REG_START   = 3'd0;
  localparam logic [2:0] REG_LEN     = 3'd1;
  localparam logic [2:0] REG_PATTERN = 3'd2;
  localparam logic [2:0] REG_CTRL    = 3'd3;
  localparam logic [2:0] REG_STATUS  = 3'd4;
  localparam logic [2:0] REG_SUM     = 3'd5;

  logic                is_mem;
  logic                req_start;
  logic                reg_wr;
  logic                ack_q;
  logic                rd_pend_q;
  logic                ram_we_q;
  logic [`WORD_AW-1:0] ram_addr_q;
  logic [`WB_DW-1:0]   ram_wdata_q;
  logic [`BYTE_AW-1:0] start_q;
  logic [`BYTE_AW:0]   len_q;
  logic [7:0]          pattern_q;
  scan_op_e            op_q;
  logic                go_q;
  logic [`WB_DW-1:0]   reg_rdata;

  assign is_mem = !wb_adr_i[`BYTE_AW];

  // New transfer, not one already being answered
  assign req_start = wb_cyc_i && wb_stb_i && !ack_q && !rd_pend_q;
  assign reg_wr    = req_start && !is_mem && wb_we_i;

  // Memory reads take one extra wait state for the RAM output
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q     <= 1'b0;
      rd_pend_q <= 1'b0;
      ram_we_q  <= 1'b0;
    end
    else
    begin
      ack_q     <= (req_start && !(is_mem && !wb_we_i)) || rd_pend_q;
      rd_pend_q <= req_start && is_mem && !wb_we_i;
      ram_we_q  <= req_start && is_mem && wb_we_i;
    end
  end

  // Port A address and data, registered in the request cycle
  always_ff @(posedge clk_i)
  begin
    if (req_start && is_mem)
    begin
      ram_addr_q  <= wb_adr_i[`WORD_AW+1:2];
      ram_wdata_q <= wb_dat_i;
    end
  end

  // Engine registers
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      start_q   <= '0;
      len_q     <= '0;
      pattern_q <= '0;
      op_q      <= OP_FILL;
      go_q      <= 1'b0;
    end
    else
    begin
      go_q <= 1'b0;
      if (reg_wr)
      begin
        case (wb_adr_i[4:2])
          REG_START:   start_q   <= wb_dat_i[`BYTE_AW-1:0];
          REG_LEN:     len_q     <= wb_dat_i[`BYTE_AW:0];
          REG_PATTERN: pattern_q <= wb_dat_i[7:0];
          REG_CTRL:
          begin
            // Ignored while the engine is busy
            if (!sts_i.busy)
            begin
              op_q <= scan_op_e'(wb_dat_i[1]);
              go_q <= wb_dat_i[0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_comb
  begin
    case (wb_adr_i[4:2])
      REG_START:   reg_rdata = `WB_DW'(start_q);
      REG_LEN:     reg_rdata = `WB_DW'(len_q);
      REG_PATTERN: reg_rdata = `WB_DW'(pattern_q);
      REG_CTRL:    reg_rdata = `WB_DW'({op_q, 1'b0});
      REG_STATUS:  reg_rdata = `WB_DW'({sts_i.done, sts_i.busy});
      REG_SUM:     reg_rdata = `WB_DW'(sts_i.sum);
      default:     reg_rdata = '0;
    endcase
  end

  // Address is held by the master through the ack cycle
  assign wb_dat_o = is_mem ? ram_a_data_i : reg_rdata;
  assign wb_ack_o = ack_q;

  assign ram_a_o = '{we: ram_we_q, addr: ram_addr_q, wdata: ram_wdata_q};

  assign cmd_o = '{go: go_q, op: op_q, start: start_q, len: len_q, pattern: pattern_q};

endmodule

// ==== src/byte_scan_engine.sv ====
/* Byte scan engine on RAM port B
   Fills a byte range with a pattern or sums its bytes */

`timescale 1ns/1ps
`include "mem_settings.svh"

module byte_scan_engine (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  mem_pkg::scan_cmd_t  cmd_i,
  output mem_pkg::scan_sts_t  sts_o,
  output mem_pkg::ram_b_req_t ram_b_o,
  input  logic [7:0]          ram_b_data_i
);
  import mem_pkg::*;

  logic                busy;
  logic                start_cmd;
  logic                issue_q;
  logic                rd_vld_q;
  logic                done_q;
  logic [`BYTE_AW:0]   cnt_q;
  logic [`SUM_W-1:0]   sum_q;
  scan_op_e            op_q;
  logic [7:0]          pattern_q;
  logic [`BYTE_AW-1:0] addr_q;

  // Busy until the last read byte has been summed
  assign busy      = issue_q || rd_vld_q;
  assign start_cmd = cmd_i.go && !busy;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      issue_q  <= 1'b0;
      rd_vld_q <= 1'b0;
      done_q   <= 1'b0;
      cnt_q    <= '0;
      sum_q    <= '0;
    end
    else
    begin
      // Read data arrives one cycle after its address
      rd_vld_q <= issue_q && (op_q == OP_CSUM);
      if (start_cmd)
      begin
        issue_q <= (cmd_i.len != '0);
        done_q  <= (cmd_i.len == '0);
        cnt_q   <= cmd_i.len;
        sum_q   <= '0;
      end
      else
      begin
        if (issue_q)
        begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == 'd1)
          begin
            issue_q <= 1'b0;
            // A fill has nothing in flight after its last write
            if (op_q == OP_FILL)
            begin
              done_q <= 1'b1;
            end
          end
        end
        if (rd_vld_q)
        begin
          sum_q <= sum_q + `SUM_W'(ram_b_data_i);
          if (!issue_q)
          begin
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  // Latched command and the walking byte address, wraps at buffer end
  always_ff @(posedge clk_i)
  begin
    if (start_cmd)
    begin
      op_q      <= cmd_i.op;
      pattern_q <= cmd_i.pattern;
      addr_q    <= cmd_i.start;
    end
    else if (issue_q)
    begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign ram_b_o = '{we: issue_q && (op_q == OP_FILL), addr: addr_q, wdata: pattern_q};

  assign sts_o = '{busy: busy, done: done_q, sum: sum_q};

endmodule

// ==== src/shared_mem_top.sv ====
/* Shared packet buffer top level
   Host slave, mixed-width RAM and byte scan engine */

`timescale 1ns/1ps
`include "mem_settings.svh"

module shared_mem_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [`BYTE_AW:0] wb_adr_i,
  input  logic [`WB_DW-1:0] wb_dat_i,
  output logic [`WB_DW-1:0] wb_dat_o,
  output logic              wb_ack_o
);
  import mem_pkg::*;

  ram_a_req_t        ram_a;
  logic [`WB_DW-1:0] ram_a_data;
  ram_b_req_t        ram_b;
  logic [7:0]        ram_b_data;
  scan_cmd_t         scan_cmd;
  scan_sts_t         scan_sts;

  wb_mem_slave i_slave (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .ram_a_o      (ram_a),
    .ram_a_data_i (ram_a_data),
    .cmd_o        (scan_cmd),
    .sts_i        (scan_sts)
  );

  // Words on the host side, bytes on the engine side
  dual_port_bram #(
    .ADataWidth (`WB_DW),
    .BDataWidth (8),
    .BitDepth   (`MEM_BYTES * 8)
  ) i_bram (
    .clk_i    (clk_i),
    .a_req_i  (ram_a),
    .a_data_o (ram_a_data),
    .b_req_i  (ram_b),
    .b_data_o (ram_b_data)
  );

  byte_scan_engine i_engine (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_i        (scan_cmd),
    .sts_o        (scan_sts),
    .ram_b_o      (ram_b),
    .ram_b_data_i (ram_b_data)
  );

endmodule

// ==== dv/shared_mem_tb.sv ====
/* Testbench for the shared packet buffer
   Host word access and scan engine runs checked against a byte model */

`timescale 1ns/1ps
`include "mem_settings.svh"

module shared_mem_tb;

  localparam int BusTimeout  = 20;
  localparam int PollTimeout = 3000;
  localparam logic OpFill = 1'b0;
  localparam logic OpCsum = 1'b1;

  logic              clk_i;
  logic              arst_n_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  logic [`BYTE_AW:0] wb_adr_i;
  logic [`WB_DW-1:0] wb_dat_i;
  logic [`WB_DW-1:0] wb_dat_o;
  logic              wb_ack_o;

  // Byte image of the buffer
  logic [7:0]  model_mem [`MEM_BYTES];
  int          check_count;
  int          error_count;
  int          timeout_count;

  shared_mem_top i_dut (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_eq(input string test, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("ERR %s: expected 0x%08h, actual 0x%08h", test, exp, act);
    end
  endtask

  // One classic cycle, held until ack or timeout
  task automatic bus_cycle(input logic we, input logic [12:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int wait_cnt;
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    rdata    = '0;
    wait_cnt = 0;
    do
    begin
      @(negedge clk_i);
      wait_cnt++;
    end while (!wb_ack_o && wait_cnt < BusTimeout);
    if (wb_ack_o)
    begin
      rdata = wb_dat_o;
    end
    else
    begin
      timeout_count++;
      $display("Timeout: no bus ack for address 0x%04h", adr);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [12:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [12:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  task automatic reg_write(input logic [2:0] idx, input logic [31:0] data);
    wb_write({1'b1, 7'd0, idx, 2'b00}, data);
  endtask

  task automatic reg_read(input logic [2:0] idx, output logic [31:0] data);
    wb_read({1'b1, 7'd0, idx, 2'b00}, data);
  endtask

  function automatic logic [31:0] model_word(input int idx);
    return {model_mem[4*idx+3], model_mem[4*idx+2], model_mem[4*idx+1], model_mem[4*idx]};
  endfunction

  task automatic mem_write(input int idx, input logic [31:0] data);
    wb_write(13'(idx * 4), data);
    for (int b = 0; b < 4; b++)
    begin
      model_mem[4*idx+b] = data[8*b +: 8];
    end
  endtask

  // Compare every word of the buffer with the model
  task automatic check_buffer(input string test);
    logic [31:0] rd;
    for (int i = 0; i < `MEM_BYTES / 4; i++)
    begin
      wb_read(13'(i * 4), rd);
      check_eq(test, model_word(i), rd);
    end
  endtask

  function automatic logic [15:0] model_sum(input logic [11:0] start, input logic [12:0] len);
    logic [15:0] acc;
    logic [11:0] addr;
    acc  = '0;
    addr = start;
    for (int i = 0; i < int'(len); i++)
    begin
      acc  = acc + 16'(model_mem[addr]);
      addr = addr + 12'd1;
    end
    return acc;
  endfunction

  task automatic model_fill(input logic [11:0] start, input logic [12:0] len,
                            input logic [7:0] pattern);
    logic [11:0] addr;
    addr = start;
    for (int i = 0; i < int'(len); i++)
    begin
      model_mem[addr] = pattern;
      addr = addr + 12'd1;
    end
  endtask

  // Poll STATUS until done, returns the last STATUS value
  task automatic wait_done(input string test, output logic [31:0] sts);
    int polls;
    polls = 0;
    do
    begin
      reg_read(3'd4, sts);
      polls++;
    end while (!sts[1] && polls < PollTimeout);
    if (!sts[1])
    begin
      timeout_count++;
      $display("Timeout in %s: engine never reported done", test);
    end
  endtask

  task automatic start_engine(input logic op, input logic [11:0] start, input logic [12:0] len,
                              input logic [7:0] pattern);
    reg_write(3'd0, 32'(start));
    reg_write(3'd1, 32'(len));
    reg_write(3'd2, 32'(pattern));
    reg_write(3'd3, 32'({op, 1'b1}));
  endtask

  task automatic run_fill(input string test, input logic [11:0] start, input logic [12:0] len,
                          input logic [7:0] pattern);
    logic [31:0] sts;
    start_engine(OpFill, start, len, pattern);
    wait_done(test, sts);
    check_eq(test, 32'h2, sts);
    model_fill(start, len, pattern);
    check_buffer(test);
  endtask

  task automatic run_csum(input string test, input logic [11:0] start, input logic [12:0] len);
    logic [31:0] sts;
    logic [31:0] sum;
    start_engine(OpCsum, start, len, 8'h00);
    wait_done(test, sts);
    check_eq(test, 32'h2, sts);
    reg_read(3'd5, sum);
    check_eq(test, 32'(model_sum(start, len)), sum);
  endtask

  task automatic test_reset();
    logic [31:0] rd;
    reg_read(3'd4, rd);
    check_eq("reset_status", 32'h0, rd);
    reg_read(3'd5, rd);
    check_eq("reset_sum", 32'h0, rd);
  endtask

  // Known contents derived from the full word index
  task automatic init_buffer();
    logic [9:0] idx;
    for (int i = 0; i < `MEM_BYTES / 4; i++)
    begin
      idx = 10'(i);
      mem_write(i, {6'h15, idx, 6'h2a, ~idx});
    end
  endtask

  task automatic test_word_rw();
    int          idx_q[$];
    logic [31:0] rd;
    for (int n = 0; n < 64; n++)
    begin
      idx_q.push_back(int'($urandom_range(`MEM_BYTES / 4 - 1, 0)));
      mem_write(idx_q[n], $urandom());
    end
    foreach (idx_q[n])
    begin
      wb_read(13'(idx_q[n] * 4), rd);
      check_eq("word_rw", model_word(idx_q[n]), rd);
    end
  endtask

  task automatic test_fill();
    run_fill("fill_inside_word", 12'd41, 13'd2, 8'h5c);
    run_fill("fill_wrap", 12'd4093, 13'd9, 8'hc3);
    run_fill("fill_random", 12'($urandom_range(4095, 0)), 13'($urandom_range(300, 1)),
             8'($urandom()));
  endtask

  task automatic test_checksum();
    run_csum("csum_partial_words", 12'd5, 13'd10);
    run_csum("csum_wrap", 12'd4090, 13'd20);
    run_csum("csum_full", 12'd0, 13'd4096);
    for (int n = 0; n < 3; n++)
    begin
      run_csum("csum_random", 12'($urandom_range(4095, 0)), 13'($urandom_range(4096, 1)));
    end
  endtask

  task automatic test_zero_and_busy();
    logic [31:0] sts;
    logic [31:0] sum;
    run_csum("csum_len_zero", 12'd100, 13'd0);
    start_engine(OpCsum, 12'd200, 13'd400, 8'h00);
    reg_read(3'd4, sts);
    check_eq("busy_status", 32'h1, sts);
    // A fill request in the middle of the checksum must be dropped
    reg_write(3'd2, 32'hee);
    reg_write(3'd3, 32'h1);
    wait_done("busy_ctrl", sts);
    reg_read(3'd5, sum);
    check_eq("busy_ctrl", 32'(model_sum(12'd200, 13'd400)), sum);
    check_buffer("busy_ctrl");
  endtask

  task automatic test_unmapped();
    logic [31:0] rd;
    reg_read(3'd6, rd);
    check_eq("unmapped_read", 32'h0, rd);
    reg_write(3'd6, 32'hffff_ffff);
    reg_write(3'd7, 32'hffff_ffff);
    reg_read(3'd7, rd);
    check_eq("unmapped_read", 32'h0, rd);
    reg_read(3'd0, rd);
    check_eq("unmapped_start", 32'd200, rd);
    reg_read(3'd1, rd);
    check_eq("unmapped_len", 32'd400, rd);
    reg_read(3'd2, rd);
    check_eq("unmapped_pattern", 32'hee, rd);
    reg_read(3'd5, rd);
    check_eq("unmapped_sum", 32'(model_sum(12'd200, 13'd400)), rd);
  endtask

  initial
  begin
    void'($urandom(42763));
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    arst_n_i      = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    test_reset();
    init_buffer();
    test_word_rw();
    test_fill();
    test_checksum();
    test_zero_and_busy();
    test_unmapped();

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+include
src/mem_pkg.sv
src/dual_port_bram.sv
src/wb_mem_slave.sv
src/byte_scan_engine.sv
src/shared_mem_top.sv
dv/shared_mem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the shared packet buffer testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -sv -Wno-fatal -f project.f \
  --top-module shared_mem_tb -Mdir obj_dir -o shared_mem_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/shared_mem_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0
